// ==== bench/core_asserts.sv ====
`timescale 1ns/1ps

module core_asserts (
    input logic              clk,
    input logic              rst_n,
    input rv_pkg::reg_addr_t rs1,
    input rv_pkg::reg_addr_t rs2,
    input logic              rs_used1,
    input logic              rs_used2,
    input logic              id_valid,
    input rv_pkg::reg_addr_t id_rd,
    input logic              ex_valid,
    input rv_pkg::reg_addr_t ex_rd,
    input logic              stall
);

    logic src1_match;
    logic src2_match;
    logic dst_zero;

    assign src1_match = rs_used1 && rs1 != 5'd0 &&
                        ((id_valid && id_rd == rs1) || (ex_valid && ex_rd == rs1));
    assign src2_match = rs_used2 && rs2 != 5'd0 &&
                        ((id_valid && id_rd == rs2) || (ex_valid && ex_rd == rs2));
    // nothing in execute or memory writes a register
    assign dst_zero   = (!id_valid || id_rd == 5'd0) && (!ex_valid || ex_rd == 5'd0);

    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !stall)
        else $error("stall high right after reset");

    a_stall_match: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> (src1_match || src2_match))
        else $error("stall without a matching source register");

    a_zero_dst: assert property (@(posedge clk) disable iff (!rst_n) dst_zero |-> !stall)
        else $error("stall while no in-flight instruction has a destination");

endmodule

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int MEM_WORDS    = 256;
    localparam int AW           = $clog2(MEM_WORDS);
    localparam int HALT_TIMEOUT = 20000;

    logic              clk;
    logic              rst_n;
    logic              run;
    logic              host_we;
    rv_pkg::word_t     host_addr;
    rv_pkg::word_t     host_wdata;
    logic              retire_valid;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_data;
    logic              halted;

    rv_pkg::word_t     image [0:MEM_WORDS-1];
    bit                exact_lat [0:MEM_WORDS-1];
    rv_pkg::reg_addr_t exp_rd_q [$];
    rv_pkg::word_t     exp_data_q [$];
    int                exp_idx_q [$];
    int                grant_q [$];
    int                prog_len;
    int                exp_count;
    int                retired;
    int                cyc;
    bit                result_reported;

    core_top #(
        .MEM_WORDS (MEM_WORDS),
        .RESET_PC  (32'h0000_0000)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    bind hazard_unit core_asserts u_asserts (
        .clk      (core_tb.clk),
        .rst_n    (core_tb.rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs_used1 (rs_used1),
        .rs_used2 (rs_used2),
        .id_valid (id_valid),
        .id_rd    (id_rd),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .stall    (stall)
    );

    always #20 clk = ~clk;

    task automatic report_error(string msg);
        result_reported = 1'b1;
        $display("ERR @%0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic abort_run(string msg);
        result_reported = 1'b1;
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_rd(rv_pkg::reg_addr_t got, rv_pkg::reg_addr_t exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s is x%0d, expected x%0d", what, got, exp));
        end
    endtask

    task automatic check_word(rv_pkg::word_t got, rv_pkg::word_t exp, string what);
        if (got !== exp) begin
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_latency(int got, int lo, int hi, int idx);
        if (got < lo || got > hi) begin
            report_error($sformatf("instruction %0d retired %0d cycles after its grant",
                                   idx, got));
        end
    endtask

    function automatic rv_pkg::word_t r_type(logic [6:0] f7, rv_pkg::reg_addr_t rs2,
                                             rv_pkg::reg_addr_t rs1, rv_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, 3'b000, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::word_t i_type(logic [11:0] imm, rv_pkg::reg_addr_t rs1,
                                             logic [2:0] f3, rv_pkg::reg_addr_t rd,
                                             logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t s_type(logic [11:0] imm, rv_pkg::reg_addr_t rs2,
                                             rv_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    task automatic emit(rv_pkg::word_t w, bit exact);
        image[prog_len]     = w;
        exact_lat[prog_len] = exact;
        prog_len++;
    endtask

    task automatic add_random(int n);
        int                k;
        int                kind;
        rv_pkg::reg_addr_t rd;
        rv_pkg::reg_addr_t ra;
        rv_pkg::reg_addr_t rb;
        logic [11:0]       imm;
        logic [11:0]       off;
        for (k = 0; k < n; k++) begin
            kind = $urandom_range(0, 4);
            rd   = 5'($urandom_range(0, 12));
            ra   = 5'($urandom_range(0, 12));
            rb   = 5'($urandom_range(0, 12));
            imm  = 12'($urandom);
            off  = 12'($urandom_range(0, 15) * 4);   // few slots so loads hit earlier stores
            case (kind)
                0: emit(r_type(7'h00, rb, ra, rd), 1'b0);
                1: emit(r_type(7'h20, rb, ra, rd), 1'b0);
                2: emit(i_type(imm, ra, 3'b000, rd, rv_pkg::OPC_OPIMM), 1'b0);
                3: emit(i_type(off, 5'd31, 3'b010, rd, rv_pkg::OPC_LOAD), 1'b0);
                default: emit(s_type(off, rb, 5'd31), 1'b0);
            endcase
        end
    endtask

    task automatic build_program();
        int            i;
        rv_pkg::word_t baddr;
        for (i = 0; i < MEM_WORDS; i++) begin
            baddr        = 32'(i * 4);
            image[i]     = {~baddr[15:0], baddr[15:0]};
            exact_lat[i] = 1'b0;
        end
        prog_len = 0;
        // independent ALU ops, nothing can hold them up
        emit(i_type(12'h005, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OPIMM), 1'b1);
        emit(i_type(12'hffd, 5'd0, 3'b000, 5'd2, rv_pkg::OPC_OPIMM), 1'b1);
        emit(i_type(12'h064, 5'd0, 3'b000, 5'd3, rv_pkg::OPC_OPIMM), 1'b1);
        emit(i_type(12'h7ff, 5'd0, 3'b000, 5'd4, rv_pkg::OPC_OPIMM), 1'b1);
        emit(i_type(12'h300, 5'd0, 3'b000, 5'd31, rv_pkg::OPC_OPIMM), 1'b0);   // data base
        // dependent chain
        emit(r_type(7'h00, 5'd2, 5'd1, 5'd5), 1'b0);
        emit(r_type(7'h20, 5'd3, 5'd5, 5'd6), 1'b0);
        emit(r_type(7'h00, 5'd6, 5'd6, 5'd7), 1'b0);
        emit(r_type(7'h20, 5'd1, 5'd7, 5'd5), 1'b0);
        // store then load, then load-use
        emit(s_type(12'h008, 5'd7, 5'd31), 1'b0);
        emit(i_type(12'h008, 5'd31, 3'b010, 5'd8, rv_pkg::OPC_LOAD), 1'b0);
        emit(r_type(7'h00, 5'd8, 5'd8, 5'd9), 1'b0);
        emit(s_type(12'h00c, 5'd9, 5'd31), 1'b0);
        emit(i_type(12'h00c, 5'd31, 3'b010, 5'd10, rv_pkg::OPC_LOAD), 1'b0);
        // writes to x0 and reads of x0
        emit(i_type(12'h037, 5'd1, 3'b000, 5'd0, rv_pkg::OPC_OPIMM), 1'b0);
        emit(r_type(7'h00, 5'd2, 5'd1, 5'd0), 1'b0);
        emit(r_type(7'h00, 5'd0, 5'd0, 5'd11), 1'b0);
        emit(i_type(12'hfff, 5'd0, 3'b000, 5'd12, rv_pkg::OPC_OPIMM), 1'b0);
        add_random(120);
        emit({25'd0, rv_pkg::OPC_SYSTEM}, 1'b0);
        // three slots are fetched while ecall travels to writeback
        for (i = 0; i < 3; i++) begin
            emit(i_type(12'h000, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_OPIMM), 1'b0);
        end
        // real register writes, they would retire if fetch went on after halt
        for (i = 0; i < 5; i++) begin
            emit(i_type(12'h0a5, 5'd0, 3'b000, 5'(13 + i), rv_pkg::OPC_OPIMM), 1'b0);
        end
    endtask

    // ISA-level model of the program, records every register write in order
    function automatic int run_model();
        rv_pkg::word_t     regs [0:31];
        rv_pkg::word_t     dmem [0:MEM_WORDS-1];
        rv_pkg::word_t     inst;
        rv_pkg::word_t     a;
        rv_pkg::word_t     b;
        rv_pkg::word_t     addr;
        rv_pkg::word_t     res;
        rv_pkg::reg_addr_t rd;
        rv_pkg::op_e       op;
        int                pc;
        int                i;
        bit                stop;
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = image[i];
        end
        pc   = 0;
        stop = 1'b0;
        while (!stop && pc < MEM_WORDS) begin
            inst = dmem[pc];
            rd   = inst[11:7];
            a    = regs[inst[19:15]];
            b    = regs[inst[24:20]];
            op   = rv_pkg::op_nop;
            case (inst[6:0])
                rv_pkg::OPC_OP: begin
                    if (inst[14:12] == 3'b000 && inst[31:25] == 7'h00) op = rv_pkg::op_add;
                    if (inst[14:12] == 3'b000 && inst[31:25] == 7'h20) op = rv_pkg::op_sub;
                end
                rv_pkg::OPC_OPIMM:  if (inst[14:12] == 3'b000) op = rv_pkg::op_addi;
                rv_pkg::OPC_LOAD:   if (inst[14:12] == 3'b010) op = rv_pkg::op_lw;
                rv_pkg::OPC_STORE:  if (inst[14:12] == 3'b010) op = rv_pkg::op_sw;
                rv_pkg::OPC_SYSTEM: if (inst[31:7] == 25'd0) op = rv_pkg::op_ecall;
                default: op = rv_pkg::op_nop;
            endcase
            res = '0;
            case (op)
                rv_pkg::op_add:  res = a + b;
                rv_pkg::op_sub:  res = a - b;
                rv_pkg::op_addi: res = a + {{20{inst[31]}}, inst[31:20]};
                rv_pkg::op_lw: begin
                    addr = a + {{20{inst[31]}}, inst[31:20]};
                    res  = dmem[addr[AW+1:2]];
                end
                rv_pkg::op_sw: begin
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    dmem[addr[AW+1:2]] = b;
                end
                rv_pkg::op_ecall: stop = 1'b1;
                default: res = '0;
            endcase
            if ((op == rv_pkg::op_add || op == rv_pkg::op_sub || op == rv_pkg::op_addi ||
                 op == rv_pkg::op_lw) && rd != 5'd0) begin
                regs[rd] = res;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
                exp_idx_q.push_back(pc);
            end
            pc++;
        end
        return exp_rd_q.size();
    endfunction

    // values sampled at the rising edge are the ones of the cycle that just ended
    always @(posedge clk) begin
        int idx;
        int lat;
        if (rst_n) begin
            cyc = cyc + 1;
            if (uut.if_gnt) begin
                grant_q.push_back(cyc);
            end
            if (retire_valid) begin
                if (halted) begin
                    abort_run("a register write retired after the core halted");
                end
                if (retired >= exp_count) begin
                    abort_run("the core retired more register writes than the model predicts");
                end
                check_rd(retire_rd, exp_rd_q[retired], "retire_rd");
                check_word(retire_data, exp_data_q[retired], "retire_data");
                idx = exp_idx_q[retired];
                if (idx >= grant_q.size()) begin
                    abort_run("a register write retired for an instruction never fetched");
                end
                lat = cyc - grant_q[idx];
                if (exact_lat[idx]) begin
                    check_latency(lat, 4, 4, idx);
                end else begin
                    check_latency(lat, 4, HALT_TIMEOUT, idx);
                end
                retired++;
            end
        end
    end

    initial begin
        int i;
        int waited;
        clk             = 1'b0;
        rst_n           = 1'b0;
        run             = 1'b0;
        host_we         = 1'b0;
        host_addr       = '0;
        host_wdata      = '0;
        retired         = 0;
        cyc             = 0;
        result_reported = 1'b0;
        void'($urandom(32'hdd7e_236c));
        build_program();
        exp_count = run_model();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (halted !== 1'b0 || retire_valid !== 1'b0) begin
            abort_run("halted or retire_valid is not low after reset");
        end

        // the host owns the memory while run is low
        for (i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            host_we    = 1'b1;
            host_addr  = 32'(i * 4);
            host_wdata = image[i];
        end
        @(negedge clk);
        host_we = 1'b0;
        run     = 1'b1;

        waited = 0;
        while (halted !== 1'b1 && waited < HALT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (halted !== 1'b1) begin
            abort_run("timeout, the core never raised halted");
        end

        waited = 0;
        while (waited < 12) begin   // quiet period, any late retire is caught above
            @(negedge clk);
            waited++;
        end

        if (retired != exp_count || halted !== 1'b1) begin
            report_error($sformatf("%0d writes retired, model expects %0d, halted %b",
                                   retired, exp_count, halted));
        end else begin
            result_reported = 1'b1;
            $display("sim passed");
            $finish;
        end
    end

    // a run stopped by an assertion still ends with a verdict
    final begin
        if (!result_reported) begin
            $display("sim failed");
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module core_tb -f sources.f -o core_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/core_sim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "simulation ended without passing"; exit 1; }
exit 0

// ==== sources.f ====
verilog/rv_pkg.sv
verilog/unified_memory.sv
verilog/mem_arbiter.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/lsu_stage.sv
verilog/core_top.sv
bench/core_asserts.sv
bench/core_tb.sv

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
    parameter int            MEM_WORDS = 256,
    parameter rv_pkg::word_t RESET_PC  = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              host_we,
    input  rv_pkg::word_t     host_addr,
    input  rv_pkg::word_t     host_wdata,
    output logic              retire_valid,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data,
    output logic              halted
);

    localparam int AW = $clog2(MEM_WORDS);

    logic              if_req;
    logic              if_gnt;
    rv_pkg::word_t     if_addr;
    rv_pkg::word_t     if_rdata;
    logic              if_valid;
    rv_pkg::word_t     if_inst;
    logic              stall;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic              rs_used1;
    logic              rs_used2;
    logic              id_valid;
    rv_pkg::op_e       id_op;
    rv_pkg::reg_addr_t id_rd;
    rv_pkg::word_t     id_a;
    rv_pkg::word_t     id_b;
    rv_pkg::word_t     id_sdata;
    logic              ex_valid;
    rv_pkg::op_e       ex_op;
    rv_pkg::reg_addr_t ex_rd;
    rv_pkg::word_t     ex_result;
    rv_pkg::word_t     ex_sdata;
    logic              ls_req;
    logic              ls_we;
    rv_pkg::word_t     ls_addr;
    rv_pkg::word_t     ls_wdata;
    rv_pkg::word_t     ls_rdata;
    logic              mem_we;
    logic [AW-1:0]     mem_addr;
    rv_pkg::word_t     mem_wdata;
    rv_pkg::word_t     mem_rdata;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .stall    (stall),
        .halted   (halted),
        .if_req   (if_req),
        .if_addr  (if_addr),
        .if_gnt   (if_gnt),
        .if_rdata (if_rdata),
        .if_valid (if_valid),
        .if_inst  (if_inst)
    );

    // the MEM/WB register drives the retire port directly
    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_valid (if_valid),
        .if_inst  (if_inst),
        .stall    (stall),
        .wb_valid (retire_valid),
        .wb_rd    (retire_rd),
        .wb_data  (retire_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs_used1 (rs_used1),
        .rs_used2 (rs_used2),
        .id_valid (id_valid),
        .id_op    (id_op),
        .id_rd    (id_rd),
        .id_a     (id_a),
        .id_b     (id_b),
        .id_sdata (id_sdata)
    );

    hazard_unit u_hazard (
        .rs1      (rs1),
        .rs2      (rs2),
        .rs_used1 (rs_used1),
        .rs_used2 (rs_used2),
        .if_valid (if_valid),
        .id_valid (id_valid),
        .id_rd    (id_rd),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .wb_valid (retire_valid),
        .wb_rd    (retire_rd),
        .stall    (stall)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_valid  (id_valid),
        .id_op     (id_op),
        .id_rd     (id_rd),
        .id_a      (id_a),
        .id_b      (id_b),
        .id_sdata  (id_sdata),
        .ex_valid  (ex_valid),
        .ex_op     (ex_op),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .ex_sdata  (ex_sdata)
    );

    lsu_stage u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_op     (ex_op),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .ex_sdata  (ex_sdata),
        .ls_req    (ls_req),
        .ls_we     (ls_we),
        .ls_addr   (ls_addr),
        .ls_wdata  (ls_wdata),
        .ls_rdata  (ls_rdata),
        .wb_valid  (retire_valid),
        .wb_rd     (retire_rd),
        .wb_data   (retire_data),
        .halted    (halted)
    );

    mem_arbiter #(
        .MEM_WORDS (MEM_WORDS)
    ) u_arbiter (
        .run        (run),
        .if_req     (if_req),
        .if_addr    (if_addr),
        .if_gnt     (if_gnt),
        .if_rdata   (if_rdata),
        .ls_req     (ls_req),
        .ls_we      (ls_we),
        .ls_addr    (ls_addr),
        .ls_wdata   (ls_wdata),
        .ls_rdata   (ls_rdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    unified_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_memory (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              if_valid,
    input  rv_pkg::word_t     if_inst,
    input  logic              stall,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output logic              rs_used1,
    output logic              rs_used2,
    output logic              id_valid,
    output rv_pkg::op_e       id_op,
    output rv_pkg::reg_addr_t id_rd,
    output rv_pkg::word_t     id_a,
    output rv_pkg::word_t     id_b,
    output rv_pkg::word_t     id_sdata
);

    rv_pkg::word_t     regs [0:31];
    rv_pkg::op_e       dec_op;
    rv_pkg::reg_addr_t dec_rd;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_s;
    rv_pkg::word_t     rs1_val;
    rv_pkg::word_t     rs2_val;
    rv_pkg::word_t     dec_b;
    logic [6:0]        funct7;
    logic [2:0]        funct3;

    assign funct7 = if_inst[31:25];
    assign funct3 = if_inst[14:12];
    assign rs1    = if_inst[19:15];
    assign rs2    = if_inst[24:20];
    assign imm_i  = {{20{if_inst[31]}}, if_inst[31:20]};
    assign imm_s  = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};

    // x0 reads zero, a write in the same cycle is passed straight through
    function automatic rv_pkg::word_t read_reg(rv_pkg::reg_addr_t ra);
        if (ra == 5'd0) begin
            return '0;
        end else if (wb_valid && wb_rd == ra) begin
            return wb_data;
        end
        return regs[ra];
    endfunction

    assign rs1_val = read_reg(rs1);
    assign rs2_val = read_reg(rs2);

    always_comb begin
        dec_op = rv_pkg::op_nop;
        case (if_inst[6:0])
            rv_pkg::OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    dec_op = rv_pkg::op_add;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    dec_op = rv_pkg::op_sub;
                end
            end
            rv_pkg::OPC_OPIMM: begin
                if (funct3 == 3'b000) begin
                    dec_op = rv_pkg::op_addi;
                end
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_op = rv_pkg::op_lw;   // word loads only
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_op = rv_pkg::op_sw;
                end
            end
            rv_pkg::OPC_SYSTEM: begin
                if (if_inst[31:7] == 25'd0) begin
                    dec_op = rv_pkg::op_ecall;
                end
            end
            default: dec_op = rv_pkg::op_nop;
        endcase
    end

    always_comb begin
        rs_used1 = 1'b0;
        rs_used2 = 1'b0;
        dec_rd   = '0;   // no destination for stores, ecall and no-ops
        dec_b    = imm_i;
        case (dec_op)
            rv_pkg::op_add, rv_pkg::op_sub: begin
                rs_used1 = 1'b1;
                rs_used2 = 1'b1;
                dec_rd   = if_inst[11:7];
                dec_b    = rs2_val;
            end
            rv_pkg::op_addi, rv_pkg::op_lw: begin
                rs_used1 = 1'b1;
                dec_rd   = if_inst[11:7];
            end
            rv_pkg::op_sw: begin
                rs_used1 = 1'b1;
                rs_used2 = 1'b1;
                dec_b    = imm_s;
            end
            default: dec_rd = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            id_op    <= rv_pkg::op_nop;
            id_rd    <= '0;
        end else if (stall || !if_valid) begin
            id_valid <= 1'b0;   // bubble
            id_op    <= rv_pkg::op_nop;
            id_rd    <= '0;
        end else begin
            id_valid <= 1'b1;
            id_op    <= dec_op;
            id_rd    <= dec_rd;
        end
    end

    always_ff @(posedge clk) begin
        id_a     <= rs1_val;
        id_b     <= dec_b;
        id_sdata <= rs2_val;
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  rv_pkg::op_e       id_op,
    input  rv_pkg::reg_addr_t id_rd,
    input  rv_pkg::word_t     id_a,
    input  rv_pkg::word_t     id_b,
    input  rv_pkg::word_t     id_sdata,
    output logic              ex_valid,
    output rv_pkg::op_e       ex_op,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::word_t     ex_result,
    output rv_pkg::word_t     ex_sdata
);

    rv_pkg::word_t alu_out;

    // for lw and sw the sum is the byte address
    assign alu_out = (id_op == rv_pkg::op_sub) ? id_a - id_b : id_a + id_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_op    <= rv_pkg::op_nop;
            ex_rd    <= '0;
        end else begin
            ex_valid <= id_valid;
            ex_op    <= id_op;
            ex_rd    <= id_rd;
        end
    end

    always_ff @(posedge clk) begin
        ex_result <= alu_out;
        ex_sdata  <= id_sdata;
    end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          run,
    input  logic          stall,
    input  logic          halted,
    output logic          if_req,
    output rv_pkg::word_t if_addr,
    input  logic          if_gnt,
    input  rv_pkg::word_t if_rdata,
    output logic          if_valid,
    output rv_pkg::word_t if_inst
);

    rv_pkg::word_t pc;

    assign if_req  = run && !halted && !stall;
    assign if_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_valid <= if_gnt;   // a lost grant leaves a bubble in IF/ID
            if (if_gnt) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && if_gnt) begin
            if_inst <= if_rdata;
        end
    end

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  logic              rs_used1,
    input  logic              rs_used2,
    input  logic              if_valid,
    input  logic              id_valid,
    input  rv_pkg::reg_addr_t id_rd,
    input  logic              ex_valid,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    output logic              stall
);

    logic hit1;
    logic hit2;

    // a producer already in writeback is read through the register file bypass,
    // so wb_valid and wb_rd never hold decode back
    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        if (rs_used1 && rs1 != 5'd0) begin
            hit1 = (id_valid && id_rd == rs1) ||   // producer in execute
                   (ex_valid && ex_rd == rs1);     // producer in memory
        end
        if (rs_used2 && rs2 != 5'd0) begin
            hit2 = (id_valid && id_rd == rs2) ||
                   (ex_valid && ex_rd == rs2);
        end
        stall = if_valid && (hit1 || hit2);
    end

endmodule

// ==== verilog/lsu_stage.sv ====
`timescale 1ns/1ps

module lsu_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  rv_pkg::op_e       ex_op,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::word_t     ex_result,
    input  rv_pkg::word_t     ex_sdata,
    output logic              ls_req,
    output logic              ls_we,
    output rv_pkg::word_t     ls_addr,
    output rv_pkg::word_t     ls_wdata,
    input  rv_pkg::word_t     ls_rdata,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              halted
);

    assign ls_req   = ex_valid && (ex_op == rv_pkg::op_lw || ex_op == rv_pkg::op_sw);
    assign ls_we    = ex_valid && ex_op == rv_pkg::op_sw;
    assign ls_addr  = ex_result;
    assign ls_wdata = ex_sdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= ex_valid && ex_rd != 5'd0;
            wb_rd    <= ex_rd;
            if (ex_valid && ex_op == rv_pkg::op_ecall) begin
                halted <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= (ex_op == rv_pkg::op_lw) ? ls_rdata : ex_result;
    end

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         run,
    input  logic                         if_req,
    input  rv_pkg::word_t                if_addr,
    output logic                         if_gnt,
    output rv_pkg::word_t                if_rdata,
    input  logic                         ls_req,
    input  logic                         ls_we,
    input  rv_pkg::word_t                ls_addr,
    input  rv_pkg::word_t                ls_wdata,
    output rv_pkg::word_t                ls_rdata,
    input  logic                         host_we,
    input  rv_pkg::word_t                host_addr,
    input  rv_pkg::word_t                host_wdata,
    output logic                         mem_we,
    output logic [$clog2(MEM_WORDS)-1:0] mem_addr,
    output rv_pkg::word_t                mem_wdata,
    input  rv_pkg::word_t                mem_rdata
);

    localparam int AW = $clog2(MEM_WORDS);

    logic          ls_sel;
    rv_pkg::word_t sel_addr;

    assign ls_sel = run && ls_req;
    assign if_gnt = run && if_req && !ls_req;   // load/store always wins

    always_comb begin
        if (!run) begin
            sel_addr  = host_addr;   // host owns the port while the core is idle
            mem_we    = host_we;
            mem_wdata = host_wdata;
        end else if (ls_sel) begin
            sel_addr  = ls_addr;
            mem_we    = ls_we;
            mem_wdata = ls_wdata;
        end else begin
            sel_addr  = if_addr;
            mem_we    = 1'b0;
            mem_wdata = '0;
        end
    end

    assign mem_addr = sel_addr[AW+1:2];
    assign if_rdata = if_gnt ? mem_rdata : '0;
    assign ls_rdata = ls_sel ? mem_rdata : '0;

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // internal opcodes after decode, anything unsupported becomes op_nop
    typedef enum logic [2:0] {
        op_nop,
        op_add,
        op_sub,
        op_addi,
        op_lw,
        op_sw,
        op_ecall
    } op_e;

    // RV32I major opcodes, instruction bits [6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

// ==== verilog/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(MEM_WORDS)-1:0] addr,
    input  rv_pkg::word_t                wdata,
    output rv_pkg::word_t                rdata
);

    rv_pkg::word_t mem [0:MEM_WORDS-1];

    // read data follows the address in the same cycle
    assign rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule
